// File: design/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
    input  logic               clk,
    input  logic               rst_i,
    input  mips_pkg::word_t    ex_pc_i,
    input  mips_pkg::reg_idx_t ex_rs_i,
    input  mips_pkg::reg_idx_t ex_rt_i,
    input  mips_pkg::reg_idx_t ex_rd_i,
    input  mips_pkg::word_t    ex_a_i,
    input  mips_pkg::word_t    ex_b_i,
    input  mips_pkg::word_t    ex_imm_i,
    input  logic               ex_use_imm_i,
    input  mips_pkg::alu_op_e  ex_alu_op_i,
    input  mips_pkg::mem_op_e  ex_mem_op_i,
    input  logic               ex_we_i,
    input  mips_pkg::reg_idx_t mem_rd_i,
    input  logic               mem_we_i,
    input  mips_pkg::word_t    mem_result_i,
    input  mips_pkg::reg_idx_t wb_rd_i,
    input  logic               wb_we_i,
    input  mips_pkg::word_t    wb_data_i,
    output mips_pkg::word_t    m_pc_o,
    output mips_pkg::word_t    m_result_o,
    output mips_pkg::word_t    m_store_o,
    output mips_pkg::reg_idx_t m_rd_o,
    output mips_pkg::mem_op_e  m_mem_op_o,
    output logic               m_we_o
);
    import mips_pkg::*;

    logic  fwd_a_mem;
    logic  fwd_b_mem;
    word_t op_a;
    word_t rt_val;
    word_t op_b;
    word_t alu_res;

    //////////////////////////////
    // Forwarding, EX/MEM first
    //////////////////////////////
    assign fwd_a_mem = mem_we_i && mem_rd_i == ex_rs_i;
    assign fwd_b_mem = mem_we_i && mem_rd_i == ex_rt_i;

    assign op_a   = fwd_a_mem ? mem_result_i :
                    (wb_we_i && wb_rd_i == ex_rs_i) ? wb_data_i : ex_a_i;
    assign rt_val = fwd_b_mem ? mem_result_i :
                    (wb_we_i && wb_rd_i == ex_rt_i) ? wb_data_i : ex_b_i;
    assign op_b   = ex_use_imm_i ? ex_imm_i : rt_val;

    always_comb begin
        case (ex_alu_op_i)
            alu_add: alu_res = op_a + op_b;         // Wraps, no overflow trap
            alu_sub: alu_res = op_a - op_b;
            alu_and: alu_res = op_a & op_b;
            alu_or:  alu_res = op_a | op_b;
            alu_xor: alu_res = op_a ^ op_b;
            alu_slt: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_lui: alu_res = {op_b[15:0], 16'h0000};
            default: alu_res = op_a + op_b;
        endcase
    end

    //////////////////////////////
    // EX/MEM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            m_we_o     <= 1'b0;
            m_mem_op_o <= mem_none;
        end else begin
            m_we_o     <= ex_we_i;
            m_mem_op_o <= ex_mem_op_i;
        end
    end

    always_ff @(posedge clk) begin
        m_pc_o     <= ex_pc_i;
        m_result_o <= alu_res;      // Address for loads and stores
        m_store_o  <= rt_val;
        m_rd_o     <= ex_rd_i;
    end

    // Decode must have stalled any consumer of a load still in EX/MEM
    assert property (@(posedge clk) disable iff (rst_i)
        (fwd_a_mem || fwd_b_mem) |-> !is_load(m_mem_op_o))
        else $error("operand forwarded from a load in EX/MEM");

endmodule

// File: design/instr_decode.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module instr_decode (
    input  logic               clk,
    input  logic               rst_i,
    input  mips_pkg::word_t    inst_i,
    input  mips_pkg::word_t    pc_i,
    output logic               stall_o,
    input  logic               wb_we_i,
    input  mips_pkg::reg_idx_t wb_rd_i,
    input  mips_pkg::word_t    wb_data_i,
    output mips_pkg::word_t    ex_pc_o,
    output mips_pkg::reg_idx_t ex_rs_o,
    output mips_pkg::reg_idx_t ex_rt_o,
    output mips_pkg::reg_idx_t ex_rd_o,
    output mips_pkg::word_t    ex_a_o,
    output mips_pkg::word_t    ex_b_o,
    output mips_pkg::word_t    ex_imm_o,
    output logic               ex_use_imm_o,
    output mips_pkg::alu_op_e  ex_alu_op_o,
    output mips_pkg::mem_op_e  ex_mem_op_o,
    output logic               ex_we_o
);
    import mips_pkg::*;

    word_t      id_inst;
    word_t      id_pc;
    word_t      regs [`MIPS_NUM_REGS];
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm;
    reg_idx_t   dst;
    logic       use_imm;
    logic       uses_rt;
    logic       we;
    alu_op_e    alu_op;
    mem_op_e    mem_op;

    //////////////////////////////
    // IF/ID
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_inst <= '0;              // All-zero word decodes to no write
        end else if (!stall_o) begin
            id_inst <= inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            id_pc <= pc_i;
        end
    end

    assign opcode = id_inst[31:26];
    assign rs     = id_inst[25:21];
    assign rt     = id_inst[20:16];
    assign rd     = id_inst[15:11];
    assign funct  = id_inst[5:0];

    // Register file, written from MEM/WB
    always_ff @(posedge clk) begin
        if (wb_we_i) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // Same-cycle write shows through to the read
    assign rs_val = (rs == '0) ? '0 :
                    (wb_we_i && wb_rd_i == rs) ? wb_data_i : regs[rs];
    assign rt_val = (rt == '0) ? '0 :
                    (wb_we_i && wb_rd_i == rt) ? wb_data_i : regs[rt];

    //////////////////////////////
    // Control decode
    //////////////////////////////
    always_comb begin
        imm     = {{16{id_inst[15]}}, id_inst[15:0]};
        dst     = rt;
        use_imm = 1'b1;
        uses_rt = 1'b0;
        we      = 1'b0;
        alu_op  = alu_add;              // Also the address adder
        mem_op  = mem_none;
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                dst     = rd;
                use_imm = 1'b0;
                uses_rt = 1'b1;
                we      = 1'b1;
                case (funct)
                    `MIPS_FUNCT_ADDU: alu_op = alu_add;
                    `MIPS_FUNCT_SUBU: alu_op = alu_sub;
                    `MIPS_FUNCT_AND:  alu_op = alu_and;
                    `MIPS_FUNCT_OR:   alu_op = alu_or;
                    `MIPS_FUNCT_XOR:  alu_op = alu_xor;
                    `MIPS_FUNCT_SLT:  alu_op = alu_slt;
                    default:          we     = 1'b0;
                endcase
            end
            `MIPS_OP_ADDIU: we = 1'b1;
            `MIPS_OP_ORI: begin
                imm    = {16'h0000, id_inst[15:0]};
                alu_op = alu_or;
                we     = 1'b1;
            end
            `MIPS_OP_LUI: begin
                imm    = {16'h0000, id_inst[15:0]};
                alu_op = alu_lui;
                we     = 1'b1;
            end
            `MIPS_OP_LW:  mem_op = mem_lw;
            `MIPS_OP_LH:  mem_op = mem_lh;
            `MIPS_OP_LHU: mem_op = mem_lhu;
            `MIPS_OP_LB:  mem_op = mem_lb;
            `MIPS_OP_LBU: mem_op = mem_lbu;
            `MIPS_OP_SW:  mem_op = mem_sw;
            `MIPS_OP_SH:  mem_op = mem_sh;
            `MIPS_OP_SB:  mem_op = mem_sb;
            default: ;
        endcase
        if (is_load(mem_op)) begin
            we = 1'b1;
        end
        uses_rt = uses_rt | is_store(mem_op);   // Store data comes from rt
        if (dst == '0) begin
            we = 1'b0;                  // $0 is never written
        end
    end

    // Load in ID/EX feeding this instruction
    assign stall_o = ex_we_o && is_load(ex_mem_op_o) &&
                     (ex_rd_o == rs || (uses_rt && ex_rd_o == rt));

    //////////////////////////////
    // ID/EX
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i || stall_o) begin     // Bubble
            ex_we_o     <= 1'b0;
            ex_mem_op_o <= mem_none;
            ex_rs_o     <= '0;
            ex_rt_o     <= '0;
        end else begin
            ex_we_o     <= we;
            ex_mem_op_o <= mem_op;
            ex_rs_o     <= rs;
            ex_rt_o     <= uses_rt ? rt : '0;   // No forwarding on an unread rt
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o      <= id_pc;
        ex_rd_o      <= dst;
        ex_a_o       <= rs_val;
        ex_b_o       <= rt_val;
        ex_imm_o     <= imm;
        ex_use_imm_o <= use_imm;
        ex_alu_op_o  <= alu_op;
    end

    assert property (@(posedge clk) disable iff (rst_i)
        ex_we_o |-> ex_rd_o != '0)
        else $error("register write to $0 left decode");

endmodule

// File: design/mem_writeback.sv
`timescale 1ns/1ns

module mem_writeback (
    input  logic               clk,
    input  logic               rst_i,
    input  mips_pkg::word_t    m_pc_i,
    input  mips_pkg::word_t    m_result_i,
    input  mips_pkg::word_t    m_store_i,
    input  mips_pkg::reg_idx_t m_rd_i,
    input  mips_pkg::mem_op_e  m_mem_op_i,
    input  logic               m_we_i,
    output mips_pkg::word_t    data_addr_o,
    output mips_pkg::word_t    data_wdata_o,
    output logic [3:0]         data_be_o,
    input  mips_pkg::word_t    data_rdata_i,
    output logic               wb_we_o,
    output mips_pkg::reg_idx_t wb_rd_o,
    output mips_pkg::word_t    wb_data_o,
    output mips_pkg::word_t    wb_pc_o
);
    import mips_pkg::*;

    logic [1:0]  lane;
    logic [15:0] ld_half;
    logic [7:0]  ld_byte;
    word_t       load_val;
    logic        wb_load;
    word_t       wb_alu;
    word_t       wb_mem;

    assign data_addr_o = m_result_i;
    assign lane        = m_result_i[1:0];

    //////////////////////////////
    // Store lanes
    //////////////////////////////
    always_comb begin
        data_wdata_o = m_store_i;
        data_be_o    = 4'b0000;
        case (m_mem_op_i)
            mem_sw: data_be_o = 4'b1111;
            mem_sh: begin
                data_wdata_o = {2{m_store_i[15:0]}};
                data_be_o    = lane[1] ? 4'b1100 : 4'b0011;
            end
            mem_sb: begin
                data_wdata_o = {4{m_store_i[7:0]}};     // Every lane, mask picks one
                data_be_o    = 4'b0001 << lane;
            end
            default: ;
        endcase
    end

    // Load lane pick and extension
    assign ld_half = lane[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];
    assign ld_byte = data_rdata_i[{lane, 3'b000} +: 8];

    always_comb begin
        case (m_mem_op_i)
            mem_lh:  load_val = {{16{ld_half[15]}}, ld_half};
            mem_lhu: load_val = {16'h0000, ld_half};
            mem_lb:  load_val = {{24{ld_byte[7]}}, ld_byte};
            mem_lbu: load_val = {24'h000000, ld_byte};
            default: load_val = data_rdata_i;
        endcase
    end

    //////////////////////////////
    // MEM/WB
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_we_o <= 1'b0;
            wb_load <= 1'b0;
        end else begin
            wb_we_o <= m_we_i;
            wb_load <= is_load(m_mem_op_i);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o <= m_rd_i;
        wb_pc_o <= m_pc_i;
        wb_alu  <= m_result_i;
        wb_mem  <= load_val;
    end

    assign wb_data_o = wb_load ? wb_mem : wb_alu;

    // Stores reach here with no register write from decode
    assert property (@(posedge clk) disable iff (rst_i)
        (data_be_o != 4'b0000) |-> (is_store(m_mem_op_i) && !m_we_i))
        else $error("byte enables set outside a store");

endmodule

// File: design/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Primary opcode field, inst[31:26]
`define MIPS_OP_SPECIAL   6'h00
`define MIPS_OP_ADDIU     6'h09
`define MIPS_OP_ORI       6'h0d
`define MIPS_OP_LUI       6'h0f
`define MIPS_OP_LB        6'h20
`define MIPS_OP_LH        6'h21
`define MIPS_OP_LW        6'h23
`define MIPS_OP_LBU       6'h24
`define MIPS_OP_LHU       6'h25
`define MIPS_OP_SB        6'h28
`define MIPS_OP_SH        6'h29
`define MIPS_OP_SW        6'h2b

// Funct field of SPECIAL, inst[5:0]
`define MIPS_FUNCT_ADDU   6'h21
`define MIPS_FUNCT_SUBU   6'h23
`define MIPS_FUNCT_AND    6'h24
`define MIPS_FUNCT_OR     6'h25
`define MIPS_FUNCT_XOR    6'h26
`define MIPS_FUNCT_SLT    6'h2a

`define MIPS_RESET_PC     32'h0000_0000
`define MIPS_NUM_REGS     32

`endif

// File: design/mips_core.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module mips_core (
    input  logic               clk,
    input  logic               rst_i,
    input  mips_pkg::word_t    inst_i,
    output mips_pkg::word_t    inst_addr_o,
    output mips_pkg::word_t    data_addr_o,
    output mips_pkg::word_t    data_wdata_o,
    output logic [3:0]         data_be_o,
    input  mips_pkg::word_t    data_rdata_i,
    output mips_pkg::word_t    debug_wb_pc_o,
    output logic [3:0]         debug_wb_rf_wen_o,
    output mips_pkg::reg_idx_t debug_wb_rf_wnum_o,
    output mips_pkg::word_t    debug_wb_rf_wdata_o
);
    import mips_pkg::*;

    word_t    pc;
    logic     stall;

    // ID/EX fields
    word_t    ex_pc;
    reg_idx_t ex_rs;
    reg_idx_t ex_rt;
    reg_idx_t ex_rd;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_imm;
    logic     ex_use_imm;
    alu_op_e  ex_alu_op;
    mem_op_e  ex_mem_op;
    logic     ex_we;

    // EX/MEM fields
    word_t    m_pc;
    word_t    m_result;
    word_t    m_store;
    reg_idx_t m_rd;
    mem_op_e  m_mem_op;
    logic     m_we;

    // MEM/WB write-back
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_data;
    word_t    wb_pc;

    //////////////////////////////
    // Fetch
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin   // Held during load-use
            pc <= pc + 32'd4;
        end
    end

    assign inst_addr_o = pc;

    //////////////////////////////
    // Stages
    //////////////////////////////
    instr_decode u_decode (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_i       (inst_i),
        .pc_i         (pc),
        .stall_o      (stall),
        .wb_we_i      (wb_we),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .ex_pc_o      (ex_pc),
        .ex_rs_o      (ex_rs),
        .ex_rt_o      (ex_rt),
        .ex_rd_o      (ex_rd),
        .ex_a_o       (ex_a),
        .ex_b_o       (ex_b),
        .ex_imm_o     (ex_imm),
        .ex_use_imm_o (ex_use_imm),
        .ex_alu_op_o  (ex_alu_op),
        .ex_mem_op_o  (ex_mem_op),
        .ex_we_o      (ex_we)
    );

    alu_execute u_execute (
        .clk          (clk),
        .rst_i        (rst_i),
        .ex_pc_i      (ex_pc),
        .ex_rs_i      (ex_rs),
        .ex_rt_i      (ex_rt),
        .ex_rd_i      (ex_rd),
        .ex_a_i       (ex_a),
        .ex_b_i       (ex_b),
        .ex_imm_i     (ex_imm),
        .ex_use_imm_i (ex_use_imm),
        .ex_alu_op_i  (ex_alu_op),
        .ex_mem_op_i  (ex_mem_op),
        .ex_we_i      (ex_we),
        .mem_rd_i     (m_rd),        // EX/MEM forwarding source
        .mem_we_i     (m_we),
        .mem_result_i (m_result),
        .wb_rd_i      (wb_rd),
        .wb_we_i      (wb_we),
        .wb_data_i    (wb_data),
        .m_pc_o       (m_pc),
        .m_result_o   (m_result),
        .m_store_o    (m_store),
        .m_rd_o       (m_rd),
        .m_mem_op_o   (m_mem_op),
        .m_we_o       (m_we)
    );

    mem_writeback u_result (
        .clk          (clk),
        .rst_i        (rst_i),
        .m_pc_i       (m_pc),
        .m_result_i   (m_result),
        .m_store_i    (m_store),
        .m_rd_i       (m_rd),
        .m_mem_op_i   (m_mem_op),
        .m_we_i       (m_we),
        .data_addr_o  (data_addr_o),
        .data_wdata_o (data_wdata_o),
        .data_be_o    (data_be_o),
        .data_rdata_i (data_rdata_i),
        .wb_we_o      (wb_we),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data),
        .wb_pc_o      (wb_pc)
    );

    // Debug trace straight from MEM/WB
    assign debug_wb_pc_o       = wb_pc;
    assign debug_wb_rf_wen_o   = wb_we ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum_o  = wb_rd;
    assign debug_wb_rf_wdata_o = wb_data;

endmodule

// File: design/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui     // Immediate into the upper half
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lw,
        mem_lh,
        mem_lhu,
        mem_lb,
        mem_lbu,
        mem_sw,
        mem_sh,
        mem_sb
    } mem_op_e;

    function automatic logic is_load(mem_op_e op);
        return op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {mem_sw, mem_sh, mem_sb};
    endfunction

endpackage

// File: mips_core.f
+incdir+design
+incdir+testbench
design/mips_pkg.sv
design/instr_decode.sv
design/alu_execute.sv
design/mem_writeback.sv
design/mips_core.sv
testbench/tb_mips_core.sv

// File: testbench/tb_mips_model.svh
// Random program and in-order reference results, built at time zero
localparam int PROG_LEN = 48;

// Kinds 0-5 R-type, 6-8 immediates, 9-13 loads, 14-16 stores
localparam logic [5:0] R_FUNCTS [6] = '{`MIPS_FUNCT_ADDU, `MIPS_FUNCT_SUBU, `MIPS_FUNCT_AND,
                                        `MIPS_FUNCT_OR, `MIPS_FUNCT_XOR, `MIPS_FUNCT_SLT};
localparam logic [5:0] KIND_OPS [17] = '{
    `MIPS_OP_SPECIAL, `MIPS_OP_SPECIAL, `MIPS_OP_SPECIAL,
    `MIPS_OP_SPECIAL, `MIPS_OP_SPECIAL, `MIPS_OP_SPECIAL,
    `MIPS_OP_ADDIU, `MIPS_OP_ORI, `MIPS_OP_LUI,
    `MIPS_OP_LW, `MIPS_OP_LH, `MIPS_OP_LHU, `MIPS_OP_LB, `MIPS_OP_LBU,
    `MIPS_OP_SW, `MIPS_OP_SH, `MIPS_OP_SB};
localparam int KIND_SIZE [17] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 4, 2, 2, 1, 1, 4, 2, 1};

logic [31:0] lfsr_state;
word_t       imem      [64];
logic        exp_we    [64];     // Indexed by PC word
reg_idx_t    exp_rd    [64];
word_t       exp_val   [64];
logic [3:0]  exp_be    [64];     // Indexed by store order
word_t       exp_wdata [64];
word_t       mdl_mem   [16];
word_t       mdl_regs  [`MIPS_NUM_REGS];
int          exp_writes;
int          exp_stores;

// Galois LFSR, one step per bit
function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    logic        out;
    val = '0;
    for (int i = 0; i < n; i++) begin
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        val = {val[30:0], out};
    end
    return val;
endfunction

function automatic word_t fill_word(int i);
    return (32'h9e37_79b9 * (i + 1)) ^ (i << 2);
endfunction

task automatic build_program();
    int          kind;
    int          off;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    reg_idx_t    dst;
    logic [15:0] imm;
    logic        we;
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       word;
    logic [15:0] half;
    logic [7:0]  byt;
    logic [3:0]  be;
    word_t       wd;
    lfsr_state = 32'h0000_dcfc;
    exp_writes = 0;
    exp_stores = 0;
    off        = 0;
    for (int i = 0; i < 64; i++) begin
        imem[i]      = '0;
        exp_we[i]    = 1'b0;
        exp_rd[i]    = '0;
        exp_val[i]   = '0;
        exp_be[i]    = '0;
        exp_wdata[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
        mdl_mem[i] = fill_word(i);
    end
    for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        mdl_regs[i] = '0;
    end
    for (int k = 0; k < PROG_LEN; k++) begin
        kind = (k < 8) ? 7 : int'(take_bits(5) % 17);
        rs   = reg_idx_t'(take_bits(3) + 1);    // Registers 1 to 8 only
        rt   = reg_idx_t'(take_bits(3) + 1);
        rd   = reg_idx_t'(take_bits(3) + 1);
        imm  = 16'(take_bits(16));
        if (k < 8) begin
            rs = '0;                            // ori rk, $0, imm
            rt = reg_idx_t'(k + 1);
        end
        if (kind == 8 || KIND_SIZE[kind] != 0) begin
            rs = '0;                            // lui, and the memory base
        end
        if (KIND_SIZE[kind] != 0) begin
            off = int'(take_bits(6)) & ~(KIND_SIZE[kind] - 1);     // Aligned
            imm = 16'(off);
        end
        imem[k] = (kind < 6) ? {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, R_FUNCTS[kind]}
                             : {KIND_OPS[kind], rs, rt, imm};
        a    = mdl_regs[rs];
        b    = mdl_regs[rt];
        dst  = (kind < 6) ? rd : rt;
        we   = (kind < 14);
        word = mdl_mem[off[5:2]];
        half = word[16 * off[1] +: 16];
        byt  = word[8 * off[1:0] +: 8];
        case (kind)
            0:  res = a + b;
            1:  res = a - b;
            2:  res = a & b;
            3:  res = a | b;
            4:  res = a ^ b;
            5:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:  res = a + {{16{imm[15]}}, imm};
            7:  res = a | {16'h0000, imm};
            8:  res = {imm, 16'h0000};
            9:  res = word;
            10: res = {{16{half[15]}}, half};
            11: res = {16'h0000, half};
            12: res = {{24{byt[7]}}, byt};
            13: res = {24'h00_0000, byt};
            default: res = '0;
        endcase
        if (kind >= 14) begin
            be = (kind == 14) ? 4'hf : (kind == 15) ? (off[1] ? 4'hc : 4'h3)
                                                    : 4'(4'b0001 << off[1:0]);
            wd = (kind == 14) ? b : (kind == 15) ? {2{b[15:0]}} : {4{b[7:0]}};
            for (int j = 0; j < 4; j++) begin
                if (be[j]) begin
                    mdl_mem[off[5:2]][8 * j +: 8] = wd[8 * j +: 8];
                end
            end
            exp_be[exp_stores]    = be;
            exp_wdata[exp_stores] = wd;
            exp_stores++;
        end
        exp_we[k]  = we;
        exp_rd[k]  = dst;
        exp_val[k] = res;
        if (we) begin
            mdl_regs[dst] = res;
            exp_writes++;
        end
    end
endtask

// File: testbench/tb_mips_core.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module tb_mips_core;
    import mips_pkg::*;

    logic       clk = 1'b0;
    logic       rst_i = 1'b1;
    word_t      inst_i;
    word_t      inst_addr_o;
    word_t      data_addr_o;
    word_t      data_wdata_o;
    logic [3:0] data_be_o;
    word_t      data_rdata_i;
    word_t      debug_wb_pc_o;
    logic [3:0] debug_wb_rf_wen_o;
    reg_idx_t   debug_wb_rf_wnum_o;
    word_t      debug_wb_rf_wdata_o;
    word_t      dmem [16];
    int         errors = 0;
    int         cycles = 0;
    int         wb_count = 0;
    int         store_idx = 0;
    int         last_wb_pc = -1;

    `include "tb_mips_model.svh"

    localparam int CYCLE_LIMIT = 8 + 2 * PROG_LEN + 24;

    always #50 clk = ~clk;

    mips_core u_dut (
        .clk                 (clk),
        .rst_i               (rst_i),
        .inst_i              (inst_i),
        .inst_addr_o         (inst_addr_o),
        .data_addr_o         (data_addr_o),
        .data_wdata_o        (data_wdata_o),
        .data_be_o           (data_be_o),
        .data_rdata_i        (data_rdata_i),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    //////////////////////////////
    // Memories
    //////////////////////////////
    assign inst_i = (inst_addr_o < PROG_LEN * 4) ? imem[inst_addr_o[7:2]]
                                                 : 32'h0000_0000;   // No write past the end
    assign data_rdata_i = dmem[data_addr_o[5:2]];

    always @(posedge clk) begin
        for (int j = 0; j < 4; j++) begin
            if (data_be_o[j]) begin
                dmem[data_addr_o[5:2]][8 * j +: 8] <= data_wdata_o[8 * j +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst_i && debug_wb_rf_wen_o == 4'hf) begin
            wb_count   <= wb_count + 1;
            last_wb_pc <= int'(debug_wb_pc_o);
        end
        if (!rst_i && data_be_o != 4'h0) begin
            store_idx <= store_idx + 1;     // Stores leave MEM in program order
        end
    end

    function automatic word_t lane_mask(logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////
    assert property (@(posedge clk) $fell(rst_i) |->
        inst_addr_o == `MIPS_RESET_PC && data_be_o == 4'h0 && debug_wb_rf_wen_o == 4'h0)
        else begin
            errors++;
            $display("CHECK FAILED inst_addr_o %h data_be_o %h debug_wb_rf_wen_o %h after reset",
                     $sampled(inst_addr_o), $sampled(data_be_o), $sampled(debug_wb_rf_wen_o));
        end

    assert property (@(posedge clk) disable iff (rst_i)
        debug_wb_rf_wen_o == 4'hf |-> exp_we[debug_wb_pc_o[7:2]])
        else begin
            errors++;
            $display("Register write at pc %h where the program has none",
                     $sampled(debug_wb_pc_o));
        end

    assert property (@(posedge clk) disable iff (rst_i)
        debug_wb_rf_wen_o == 4'hf |-> debug_wb_rf_wnum_o == exp_rd[debug_wb_pc_o[7:2]])
        else begin
            errors++;
            $display("CHECK FAILED debug_wb_rf_wnum_o pc %h got %h expected %h",
                     $sampled(debug_wb_pc_o), $sampled(debug_wb_rf_wnum_o),
                     exp_rd[$sampled(debug_wb_pc_o[7:2])]);
        end

    // Covers ALU results, immediates, forwarding and load extraction
    assert property (@(posedge clk) disable iff (rst_i)
        debug_wb_rf_wen_o == 4'hf |-> debug_wb_rf_wdata_o == exp_val[debug_wb_pc_o[7:2]])
        else begin
            errors++;
            $display("CHECK FAILED debug_wb_rf_wdata_o pc %h got %h expected %h",
                     $sampled(debug_wb_pc_o), $sampled(debug_wb_rf_wdata_o),
                     exp_val[$sampled(debug_wb_pc_o[7:2])]);
        end

    assert property (@(posedge clk) disable iff (rst_i)
        debug_wb_rf_wen_o == 4'hf |-> int'(debug_wb_pc_o) > last_wb_pc)
        else begin
            errors++;
            $display("Write-back pc %h is not above the previous one %h",
                     $sampled(debug_wb_pc_o), $sampled(last_wb_pc));
        end

    assert property (@(posedge clk) disable iff (rst_i)
        data_be_o != 4'h0 |-> data_be_o == exp_be[store_idx])
        else begin
            errors++;
            $display("CHECK FAILED data_be_o got %h expected %h",
                     $sampled(data_be_o), exp_be[$sampled(store_idx)]);
        end

    assert property (@(posedge clk) disable iff (rst_i)
        data_be_o != 4'h0 |-> (data_wdata_o & lane_mask(data_be_o)) ==
                              (exp_wdata[store_idx] & lane_mask(data_be_o)))
        else begin
            errors++;
            $display("CHECK FAILED data_wdata_o got %h expected %h in lanes %h",
                     $sampled(data_wdata_o), exp_wdata[$sampled(store_idx)],
                     $sampled(data_be_o));
        end

    //////////////////////////////
    // Stimulus and summary
    //////////////////////////////
    initial begin
        build_program();
        for (int i = 0; i < 16; i++) begin
            dmem[i] = fill_word(i);
        end
        repeat (8) @(negedge clk);
        rst_i = 1'b0;
        // Done once the last instruction has left MEM/WB
        while (inst_addr_o < (PROG_LEN + 5) * 4 && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
        end
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("Timeout after %0d cycles, the program never drained", cycles);
        end
        assert (wb_count == exp_writes)
            else begin
                errors++;
                $display("CHECK FAILED register write count got %h expected %h",
                         wb_count, exp_writes);
            end
        for (int i = 0; i < 16; i++) begin
            assert (dmem[i] == mdl_mem[i])
                else begin
                    errors++;
                    $display("CHECK FAILED dmem[%0d] got %h expected %h", i, dmem[i], mdl_mem[i]);
                end
        end
        $display("Errors %0d, register writes %0d of %0d, stores %0d of %0d",
                 errors, wb_count, exp_writes, store_idx, exp_stores);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
